//--- common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Base integer ISA word width
`define RV_XLEN 32

// Architectural registers x0 to x31
`define RV_NUM_REGS 32

// First PC after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- common/rv_isa_pkg.sv
`include "rv_settings.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;                // Data, address or immediate
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t; // Register index field
    typedef logic [6:0] opcode_t;                       // instr[6:0]

    // Major opcodes of RV32I
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011; // No CSRs, decodes as NOP

    // Instruction class
    typedef enum logic [3:0] {
        OP,
        OPIMM,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        LUI,
        AUIPC,
        NOP     // SYSTEM, illegal, reserved
    } i_type_e;

    // ALU operation
    typedef enum logic [3:0] {
        Add,
        Sub,
        Xor,
        Or,
        And,
        Sll,
        Srl,
        Sra,
        Slt,
        Sltu,
        NoAlu   // Result forced to zero
    } alu_func_e;

    // Branch condition
    typedef enum logic [2:0] {
        Eq,
        Neq,
        Lt,
        Ge,
        Ltu,
        Geu,
        Dbr     // Not a branch
    } br_func_e;

endpackage

//--- common/rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoder output, consumed by execute in the same cycle
    typedef struct packed {
        i_type_e   i_type;
        alu_func_e alu_func;
        br_func_e  br_func;
        reg_idx_t  rs1;      // Zero when the form has no rs1
        reg_idx_t  rs2;      // Zero when the form has no rs2
        reg_idx_t  rd;       // Zero for S and B forms
        word_t     imm;      // Already sign-extended
    } decoded_t;

    // Everything one instruction does to the machine state
    typedef struct packed {
        logic     wb_en;     // Class writes a register
        reg_idx_t wb_rd;
        word_t    wb_data;
        logic     br_taken;  // Taken branch or any jump
        word_t    next_pc;
        logic     mem_valid; // Load or store request strobe
        logic     mem_we;    // Store
        word_t    mem_addr;
        word_t    mem_wdata;
    } exec_result_t;

endpackage

//--- decode/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    // Encoding form picks register fields and immediate layout
    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_N} fmt_e;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    fmt_e       fmt;
    word_t      imm;
    logic       legal;      // Low for reserved funct, SYSTEM, unknown opcode
    i_type_e    i_type;
    alu_func_e  alu_func;
    br_func_e   br_func;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25]; // Also imm[11:5] of shift immediates

    always_comb begin
        case (opcode)
            OPC_OP:                       fmt = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt = FMT_I;
            OPC_STORE:                    fmt = FMT_S;
            OPC_BRANCH:                   fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:           fmt = FMT_U;
            OPC_JAL:                      fmt = FMT_J;
            default:                      fmt = FMT_N; // SYSTEM lands here too
        endcase
    end

    // All immediates sign-extended from instr[31]
    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
            FMT_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            FMT_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'b0};
            FMT_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0; // R form has none
        endcase
    end

    // Class, ALU and branch function from opcode and funct fields
    always_comb begin
        i_type   = NOP;
        alu_func = NoAlu;
        br_func  = Dbr;
        legal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                i_type = OP;
                legal  = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'h0}: alu_func = Add;
                    {7'h20, 3'h0}: alu_func = Sub;
                    {7'h00, 3'h1}: alu_func = Sll;
                    {7'h00, 3'h2}: alu_func = Slt;
                    {7'h00, 3'h3}: alu_func = Sltu;
                    {7'h00, 3'h4}: alu_func = Xor;
                    {7'h00, 3'h5}: alu_func = Srl;
                    {7'h20, 3'h5}: alu_func = Sra;
                    {7'h00, 3'h6}: alu_func = Or;
                    {7'h00, 3'h7}: alu_func = And;
                    default:       legal    = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                i_type = OPIMM;
                legal  = 1'b1;
                case (funct3)
                    3'h0: alu_func = Add;
                    3'h2: alu_func = Slt;
                    3'h3: alu_func = Sltu;
                    3'h4: alu_func = Xor;
                    3'h6: alu_func = Or;
                    3'h7: alu_func = And;
                    3'h1: begin
                        if (funct7 == 7'h00) alu_func = Sll;
                        else legal = 1'b0;
                    end
                    default: begin // funct3 5 is a logical or arithmetic right shift
                        if (funct7 == 7'h00) alu_func = Srl;
                        else if (funct7 == 7'h20) alu_func = Sra;
                        else legal = 1'b0;
                    end
                endcase
            end
            OPC_LOAD: begin
                i_type   = LOAD;
                alu_func = Add;                             // rs1 + imm
                legal    = funct3 inside {3'h0, 3'h1, 3'h2, 3'h4, 3'h5};
            end
            OPC_STORE: begin
                i_type   = STORE;
                alu_func = Add;
                legal    = funct3 inside {3'h0, 3'h1, 3'h2}; // SB, SH, SW
            end
            OPC_BRANCH: begin
                i_type = BRANCH;
                legal  = 1'b1;
                case (funct3)
                    3'h0:    br_func = Eq;
                    3'h1:    br_func = Neq;
                    3'h4:    br_func = Lt;
                    3'h5:    br_func = Ge;
                    3'h6:    br_func = Ltu;
                    3'h7:    br_func = Geu;
                    default: legal   = 1'b0; // funct3 2 and 3 reserved
                endcase
            end
            OPC_JAL: begin
                i_type = JAL;
                legal  = 1'b1;
            end
            OPC_JALR: begin
                i_type   = JALR;
                alu_func = Add;           // Target sum
                legal    = (funct3 == 3'h0);
            end
            OPC_LUI: begin
                i_type = LUI;
                legal  = 1'b1;
            end
            OPC_AUIPC: begin
                i_type = AUIPC;
                legal  = 1'b1;
            end
            default: ;                    // Stays NOP
        endcase
    end

    // Illegal encodings leave the struct cleared
    always_comb begin
        dec          = '0;
        dec.i_type   = NOP;
        dec.alu_func = NoAlu;
        dec.br_func  = Dbr;
        if (legal) begin
            dec.i_type   = i_type;
            dec.alu_func = alu_func;
            dec.br_func  = br_func;
            dec.rs1      = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? instr[19:15] : '0;
            dec.rs2      = (fmt inside {FMT_R, FMT_S, FMT_B}) ? instr[24:20] : '0;
            dec.rd       = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? instr[11:7] : '0;
            dec.imm      = imm;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module reg_file import rv_isa_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    word_t regs [1:`RV_NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data; // Visible to reads after this edge
        end
    end

    // Combinational reads, x0 hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // The core filters rd == 0 before it raises we
    assert property (@(posedge clk_in) disable iff (!rst_n) we |-> rd != '0)
        else $error("reg_file: write strobe to x0");

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*; (
    input  alu_func_e func,
    input  word_t     a,
    input  word_t     b,
    output word_t     y
);

    logic [4:0] shamt; // RV32I shifts use only b[4:0]

    assign shamt = b[4:0];

    always_comb begin
        case (func)
            Add:  y = a + b;
            Sub:  y = a - b;
            Xor:  y = a ^ b;
            Or:   y = a | b;
            And:  y = a & b;
            Sll:  y = a << shamt;
            Srl:  y = a >> shamt;                      // Zero fill
            Sra:  y = word_t'($signed(a) >>> shamt);   // Sign fill
            Slt:  y = word_t'($signed(a) < $signed(b));
            Sltu: y = word_t'(a < b);
            default: begin
                y = '0;                                // NoAlu
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  decoded_t     dec,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    input  word_t        pc,
    output exec_result_t res
);

    word_t alu_b;
    word_t alu_y;
    word_t pc_plus4;   // Fall-through and link value
    word_t pc_imm;     // Branch, JAL and AUIPC
    word_t target;
    logic  br_cond;
    logic  taken;

    // Register operand only for R form
    assign alu_b = (dec.i_type == OP) ? rs2_data : dec.imm;

    alu alu_i (
        .func (dec.alu_func),
        .a    (rs1_data),
        .b    (alu_b),
        .y    (alu_y)
    );

    assign pc_plus4 = pc + word_t'(4);
    assign pc_imm   = pc + dec.imm;

    always_comb begin
        case (dec.br_func)
            Eq:      br_cond = (rs1_data == rs2_data);
            Neq:     br_cond = (rs1_data != rs2_data);
            Lt:      br_cond = ($signed(rs1_data) < $signed(rs2_data));
            Ge:      br_cond = ($signed(rs1_data) >= $signed(rs2_data));
            Ltu:     br_cond = (rs1_data < rs2_data);
            Geu:     br_cond = (rs1_data >= rs2_data);
            default: br_cond = 1'b0; // Dbr
        endcase
    end

    // Jumps always count as taken
    assign taken  = (dec.i_type == BRANCH && br_cond) || dec.i_type inside {JAL, JALR};
    assign target = (dec.i_type == JALR) ? (alu_y & ~word_t'(1)) : pc_imm;

    always_comb begin
        res          = '0;
        res.br_taken = taken;
        res.next_pc  = taken ? target : pc_plus4;
        case (dec.i_type)
            OP, OPIMM: begin
                res.wb_en   = 1'b1;
                res.wb_data = alu_y;
            end
            JAL, JALR: begin
                res.wb_en   = 1'b1;
                res.wb_data = pc_plus4;
            end
            LUI: begin
                res.wb_en   = 1'b1;
                res.wb_data = dec.imm;   // Already shifted by decode
            end
            AUIPC: begin
                res.wb_en   = 1'b1;
                res.wb_data = pc_imm;
            end
            LOAD: begin
                res.mem_valid = 1'b1;    // Address only, no data returns
                res.mem_addr  = alu_y;
            end
            STORE: begin
                res.mem_valid = 1'b1;
                res.mem_we    = 1'b1;
                res.mem_addr  = alu_y;
                res.mem_wdata = rs2_data;
            end
            default: ;                   // BRANCH and NOP
        endcase
        if (res.wb_en) begin
            res.wb_rd = dec.rd;
        end
    end

endmodule

`default_nettype wire

//--- src/rv_exec_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_settings.svh"

module rv_exec_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_n,
    input  word_t        instr,
    input  logic         instr_valid,
    output word_t        pc,
    output exec_result_t result,
    output logic         result_valid
);

    decoded_t     dec;
    word_t        rs1_data;
    word_t        rs2_data;
    exec_result_t res;       // Combinational result of the current instr
    logic         rf_we;

    decode decode_i (
        .instr (instr),
        .dec   (dec)
    );

    reg_file reg_file_i (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (res.wb_rd),
        .rd_data  (res.wb_data)
    );

    execute execute_i (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .res      (res)
    );

    // Writes to x0 are dropped here
    assign rf_we = instr_valid && res.wb_en && (res.wb_rd != '0);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pc <= word_t'(`RV_RESET_PC);
        end else if (instr_valid) begin
            pc <= res.next_pc; // Same edge as the register write
        end
    end

    // Output register with a one-cycle strobe
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= instr_valid;
            if (instr_valid) begin
                result <= res; // Held until the next instruction
            end
        end
    end

    // Loads and stores never write a register
    assert property (@(posedge clk_in) disable iff (!rst_n)
        instr_valid && res.mem_valid |-> !res.wb_en)
        else $error("rv_exec_core: memory request with a register write");

    // Without a taken branch or jump the PC falls through
    assert property (@(posedge clk_in) disable iff (!rst_n)
        instr_valid && !res.br_taken |-> res.next_pc == pc + word_t'(4))
        else $error("rv_exec_core: next_pc not pc+4 on fall-through");

endmodule

`default_nettype wire

//--- testbench/tb_rv_exec_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_exec_core import rv_isa_pkg::*, rv_pipe_pkg::*; ;

    // Per test: alu 56, branch 18, jump 6, memory 9, nop and chain 5
    localparam int NUM_INSTR = 56 + 18 + 6 + 9 + 5;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 2 + 50;

    logic         clk_in;
    logic         rst_n;
    word_t        instr;
    logic         instr_valid;
    word_t        pc;
    exec_result_t result;
    logic         result_valid;

    word_t model_regs [0:`RV_NUM_REGS-1]; // Architectural state as the ISA predicts it
    word_t model_pc;
    word_t lcg_state = 32'h206f;
    int    checks = 0;
    int    errors = 0;

    rv_exec_core dut_i (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .pc           (pc),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in; // 100 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
        return lcg_state;
    endfunction

    function automatic reg_idx_t pick_src();
        word_t r;
        r = next_rand();
        return reg_idx_t'(r[2:0]) + 5'd1; // x1..x8 hold the random values
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Instruction encoders, one per format
    function automatic word_t r_form(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_form(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_form(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_form(input logic [12:0] off, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_form(input logic [19:0] imm, input reg_idx_t rd,
                                     input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_form(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Reference ALU straight from the funct3 table of the ISA
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'h0:    return alt ? a - b : a + b;
            3'h1:    return a << b[4:0];
            3'h2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'h3:    return (a < b) ? 32'd1 : 32'd0;
            3'h4:    return a ^ b;
            3'h5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'h6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'h0:    return a == b;
            3'h1:    return a != b;
            3'h4:    return $signed(a) < $signed(b);
            3'h5:    return $signed(a) >= $signed(b);
            3'h6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exec_result_t fall_through();
        exec_result_t r;
        r = '0;
        r.next_pc = model_pc + 32'd4;
        return r;
    endfunction

    function automatic exec_result_t writeback(input reg_idx_t rd, input word_t data);
        exec_result_t r;
        r = fall_through();
        r.wb_en   = 1'b1;
        r.wb_rd   = rd;
        r.wb_data = data;
        return r;
    endfunction

    task automatic result_check(input exec_result_t got, input exec_result_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s result %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic word_check(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic index_check(input reg_idx_t got, input reg_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Called at a falling edge while result_valid should be high
    task automatic take_result(input exec_result_t exp, input string what);
        if (result_valid !== 1'b1) begin
            errors++;
            $display("Error at %0t: result_valid low when a result was due (%s)", $time, what);
        end
        result_check(result, exp, what);
        word_check(pc, exp.next_pc, {what, " pc"});
        if (exp.wb_en && exp.wb_rd != 5'd0) begin
            model_regs[exp.wb_rd] = exp.wb_data;
        end
        model_pc = exp.next_pc;
    endtask

    task automatic issue_one(input word_t i, input exec_result_t exp);
        int waited;
        @(posedge clk_in);
        instr       <= i;
        instr_valid <= 1'b1;
        @(posedge clk_in);
        instr_valid <= 1'b0;     // One-cycle strobe
        waited = 0;
        @(negedge clk_in);
        while (result_valid !== 1'b1 && waited < 4) begin
            @(negedge clk_in);
            waited++;
        end
        if (result_valid !== 1'b1) begin
            errors++;
            $display("Error at %0t: no result_valid within 4 cycles of instr %h", $time, i);
        end else begin
            take_result(exp, $sformatf("instr %h", i));
        end
    endtask

    // Two strobes on consecutive edges, second reads the first one's rd
    task automatic issue_pair(input word_t i1, input exec_result_t e1,
                              input word_t i2, input exec_result_t e2);
        @(posedge clk_in);
        instr       <= i1;
        instr_valid <= 1'b1;
        @(posedge clk_in);
        instr       <= i2;
        @(negedge clk_in);
        take_result(e1, $sformatf("first of pair %h", i1));
        @(posedge clk_in);
        instr_valid <= 1'b0;
        @(negedge clk_in);
        take_result(e2, $sformatf("second of pair %h", i2));
    endtask

    task automatic reset_state();
        @(negedge clk_in);
        word_check({31'b0, result_valid}, 32'd0, "result_valid after reset");
        word_check(pc, `RV_RESET_PC, "pc after reset");
        result_check(result, '0, "after reset");
    endtask

    task automatic alu_ops();
        word_t       r;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        int          n;
        int          round;
        for (n = 1; n <= 8; n++) begin
            r   = next_rand();
            rd  = reg_idx_t'(n);
            imm = {1'b1, r[10:0]};   // Always negative
            issue_one(u_form(r[31:12], rd, OPC_LUI), writeback(rd, {r[31:12], 12'h000}));
            issue_one(i_form(imm, rd, 3'h0, rd, OPC_OP_IMM),
                      writeback(rd, model_regs[rd] + sext12(imm)));
        end
        for (round = 0; round < 2; round++) begin
            for (n = 0; n < 10; n++) begin  // 8 base ops, then SUB and SRA
                f3  = (n < 8) ? n[2:0] : ((n == 8) ? 3'h0 : 3'h5);
                alt = (n >= 8);
                rs1 = pick_src();
                rs2 = pick_src();
                rd  = reg_idx_t'(9 + n);
                issue_one(r_form(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd),
                          writeback(rd, alu_model(f3, alt, model_regs[rs1], model_regs[rs2])));
            end
            for (n = 0; n < 9; n++) begin   // 8 funct3 values, then SRAI
                f3  = (n < 8) ? n[2:0] : 3'h5;
                alt = (n == 8);
                rs1 = pick_src();
                rd  = reg_idx_t'(9 + n);
                r   = next_rand();
                imm = r[11:0];
                if (f3 == 3'h1 || f3 == 3'h5) begin
                    imm = {alt ? 7'h20 : 7'h00, r[4:0]};  // shamt encoding
                end
                issue_one(i_form(imm, rs1, f3, rd, OPC_OP_IMM),
                          writeback(rd, alu_model(f3, alt, model_regs[rs1], sext12(imm))));
            end
        end
        r   = next_rand();
        imm = r[11:0];
        issue_one(i_form(imm, 5'd1, 3'h0, 5'd0, OPC_OP_IMM),
                  writeback(5'd0, model_regs[1] + sext12(imm)));
        index_check(result.wb_rd, 5'd0, "ADDI to x0 wb_rd");
        issue_one(r_form(7'h00, 5'd0, 5'd0, 3'h0, 5'd19), writeback(5'd19, 32'd0)); // x0 still 0
    endtask

    task automatic branch_conds();
        word_t        r;
        logic [12:0]  off;
        logic [2:0]   f3;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        exec_result_t exp;
        int           n;
        int           p;
        for (n = 0; n < 6; n++) begin
            f3 = (n < 2) ? n[2:0] : 3'(n + 2);
            for (p = 0; p < 3; p++) begin   // (a,b), (b,a), (a,a) cover both outcomes
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                r   = next_rand();
                off = {r[12:1], 1'b0};
                exp = fall_through();
                if (branch_model(f3, model_regs[rs1], model_regs[rs2])) begin
                    exp.br_taken = 1'b1;
                    exp.next_pc  = model_pc + {{19{off[12]}}, off};
                end
                issue_one(b_form(off, rs2, rs1, f3), exp);
            end
        end
    endtask

    task automatic jump_links();
        word_t        r;
        word_t        sum;
        logic [20:0]  off;
        logic [11:0]  imm;
        exec_result_t exp;
        int           n;
        for (n = 0; n < 2; n++) begin
            r   = next_rand();
            off = {r[20:1], 1'b0};
            exp = writeback(5'd23, model_pc + 32'd4);
            exp.br_taken = 1'b1;
            exp.next_pc  = model_pc + {{11{off[20]}}, off};
            issue_one(j_form(off, 5'd23), exp);
        end
        for (n = 0; n < 2; n++) begin
            r   = next_rand();
            imm = r[11:0];
            sum = model_regs[1] + sext12(imm);
            if (sum[0] != n[0]) begin      // Second pass forces an odd sum
                imm[0] = ~imm[0];
                sum    = model_regs[1] + sext12(imm);
            end
            exp = writeback(5'd24, model_pc + 32'd4);
            exp.br_taken = 1'b1;
            exp.next_pc  = sum & ~32'd1;
            issue_one(i_form(imm, 5'd1, 3'h0, 5'd24, OPC_JALR), exp);
        end
        for (n = 0; n < 2; n++) begin
            r = next_rand();
            issue_one(u_form(r[31:12], 5'd25, OPC_AUIPC),
                      writeback(5'd25, model_pc + {r[31:12], 12'h000}));
        end
    endtask

    task automatic mem_requests();
        word_t        r;
        logic [11:0]  imm;
        logic [2:0]   f3;
        exec_result_t exp;
        int           n;
        for (n = 0; n < 5; n++) begin      // LB LH LW LBU LHU
            f3  = (n < 3) ? n[2:0] : 3'(n + 1);
            r   = next_rand();
            imm = r[11:0];
            exp = fall_through();
            exp.mem_valid = 1'b1;
            exp.mem_addr  = model_regs[2] + sext12(imm);
            issue_one(i_form(imm, 5'd2, f3, 5'd26, OPC_LOAD), exp);
            index_check(result.wb_rd, 5'd0, "load wb_rd");
        end
        for (n = 0; n < 3; n++) begin      // SB SH SW
            r   = next_rand();
            imm = r[11:0];
            exp = fall_through();
            exp.mem_valid = 1'b1;
            exp.mem_we    = 1'b1;
            exp.mem_addr  = model_regs[4] + sext12(imm);
            exp.mem_wdata = model_regs[3];
            issue_one(s_form(imm, 5'd3, 5'd4, n[2:0]), exp);
        end
        // Load target must still hold its reset value
        issue_one(r_form(7'h00, 5'd0, 5'd26, 3'h0, 5'd27), writeback(5'd27, 32'd0));
    endtask

    task automatic nop_and_chain();
        word_t        r;
        word_t        v;
        logic [11:0]  imm;
        exec_result_t e1;
        exec_result_t e2;
        issue_one(32'hffff_ffff, fall_through());                        // Unknown opcode
        issue_one(32'h0000_0073, fall_through());                        // ECALL
        issue_one(r_form(7'h01, 5'd2, 5'd1, 3'h0, 5'd29), fall_through()); // MUL, no M ext
        r   = next_rand();
        imm = r[11:0];
        v   = model_regs[1] + sext12(imm);
        e1  = writeback(5'd27, v);
        e2  = writeback(5'd28, v + model_regs[2]);
        e2.next_pc = model_pc + 32'd8;
        issue_pair(i_form(imm, 5'd1, 3'h0, 5'd27, OPC_OP_IMM), e1,
                   r_form(7'h00, 5'd2, 5'd27, 3'h0, 5'd28), e2);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        model_pc    = `RV_RESET_PC;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk_in);
        rst_n <= 1'b1;
        reset_state();
        alu_ops();
        branch_conds();
        jump_links();
        mem_requests();
        nop_and_chain();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
decode/decode.sv
src/reg_file.sv
src/alu.sv
src/execute.sv
src/rv_exec_core.sv
testbench/tb_rv_exec_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rv_exec_core \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
